// File: Makefile
VERILATOR ?= verilator
TOP       ?= ooo_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+include
rtl/ooo_isa_pkg.sv
rtl/ooo_rob_pkg.sv
rtl/ooo_alu.sv
rtl/ooo_frontend.sv
rtl/ooo_rob.sv
rtl/ooo_commit.sv
rtl/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/ooo_checker.sv
testbench/ooo_tb.sv

// File: include/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Word widths
`define OOO_INST_LEN       16
`define OOO_REG_LEN        16

// Architectural register file
`define OOO_RF_SIZE        8
`define OOO_RF_SIZE_LOG    3

// Reorder buffer depth
`define OOO_ROB_SIZE       8
`define OOO_ROB_SIZE_LOG   3

// Instruction memory, the log size is also the PC width
`define OOO_IMEM_SIZE      32
`define OOO_IMEM_SIZE_LOG  5

// Data memory
`define OOO_DMEM_SIZE      16
`define OOO_DMEM_SIZE_LOG  4

`endif

// File: rtl/ooo_alu.sv
`include "ooo_consts.svh"

module ooo_alu
  import ooo_isa_pkg::*;
(
  input  pc_t                           pc,
  input  opcode_e                       op,
  input  data_t                         imm,
  input  data_t                         rs1_data,
  input  data_t                         rs2_data,
  input  data_t                         mem_data,
  output logic [`OOO_DMEM_SIZE_LOG-1:0] mem_addr,
  output data_t                         rd_data,
  output logic                          taken,
  output pc_t                           next_pc
);

  data_t sum;

  assign sum      = rs1_data + imm;                  // ADDI result and load address
  assign mem_addr = sum[`OOO_DMEM_SIZE_LOG-1:0];     // Wraps at the memory size
  assign taken    = (op == OP_BEQ) && (rs1_data == rs2_data);
  assign next_pc  = taken ? pc + imm[`OOO_IMEM_SIZE_LOG-1:0] : pc + 1'b1;

  always_comb begin
    case (op)
      OP_ADDI: rd_data = sum;
      OP_ADD:  rd_data = rs1_data + rs2_data;
      OP_SUB:  rd_data = rs1_data - rs2_data;
      OP_LD:   rd_data = mem_data;
      default: rd_data = '0;
    endcase
  end

endmodule

// File: rtl/ooo_commit.sv
`include "ooo_consts.svh"

module ooo_commit
  import ooo_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     head_valid,
  input  logic     head_wen,
  input  reg_idx_t head_rd,
  input  data_t    head_data,
  input  logic     head_is_br,
  input  logic     head_taken,
  input  pc_t      head_next_pc,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  output logic     squash,
  output pc_t      squash_pc,
  output logic     wb_wen,
  output reg_idx_t wb_rd,
  output data_t    rf_rs1_data,
  output data_t    rf_rs2_data
);

  data_t rf [`OOO_RF_SIZE];

  assign wb_wen    = head_valid && head_wen;
  assign wb_rd     = head_rd;
  assign squash    = head_valid && head_is_br && head_taken; // Fetch predicted not-taken
  assign squash_pc = head_next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `OOO_RF_SIZE; i++) rf[i] <= '0;
    end else if (wb_wen) begin
      rf[wb_rd] <= head_data;
    end
  end

  assign rf_rs1_data = rf[rs1_idx];
  assign rf_rs2_data = rf[rs2_idx];

endmodule

// File: rtl/ooo_core.sv
`include "ooo_consts.svh"

module ooo_core
  import ooo_isa_pkg::*;
  import ooo_rob_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          imem_we,
  input  pc_t                           imem_addr,
  input  logic [`OOO_INST_LEN-1:0]      imem_data,
  input  logic                          dmem_we,
  input  logic [`OOO_DMEM_SIZE_LOG-1:0] dmem_addr,
  input  data_t                         dmem_data,
  output logic                          commit_valid,
  output pc_t                           commit_pc,
  output logic                          commit_wen,
  output reg_idx_t                      commit_rd,
  output data_t                         commit_data
);

  // Dispatch
  pc_t      disp_pc;
  opcode_e  disp_op;
  data_t    disp_imm;
  logic     disp_wen;
  reg_idx_t disp_rd;
  logic     disp_rs1_stall;
  data_t    disp_rs1_data;
  rob_idx_t disp_rs1_link;
  logic     disp_rs2_stall;
  data_t    disp_rs2_data;
  rob_idx_t disp_rs2_link;
  logic     rob_full;
  rob_idx_t rob_tail;

  // Operand lookup
  rob_idx_t look1_idx;
  rob_idx_t look2_idx;
  logic     look1_done;
  data_t    look1_data;
  logic     look2_done;
  data_t    look2_data;

  // Head of the ROB and commit
  logic     head_valid;
  rob_idx_t head_idx;
  pc_t      head_pc;
  logic     head_wen;
  reg_idx_t head_rd;
  data_t    head_data;
  logic     head_is_br;
  logic     head_taken;
  pc_t      head_next_pc;
  logic     squash;
  pc_t      squash_pc;
  logic     wb_wen;
  reg_idx_t wb_rd;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  data_t    rf_rs1_data;
  data_t    rf_rs2_data;

  ooo_frontend u_frontend (
    .clk            (clk),
    .rst            (rst),
    .imem_we        (imem_we),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .squash         (squash),
    .squash_pc      (squash_pc),
    .rob_full       (rob_full),
    .rob_tail       (rob_tail),
    .head_idx       (head_idx),
    .wb_wen         (wb_wen),
    .wb_rd          (wb_rd),
    .look1_done     (look1_done),
    .look1_data     (look1_data),
    .look2_done     (look2_done),
    .look2_data     (look2_data),
    .rf_rs1_data    (rf_rs1_data),
    .rf_rs2_data    (rf_rs2_data),
    .rs1_idx        (rs1_idx),
    .rs2_idx        (rs2_idx),
    .look1_idx      (look1_idx),
    .look2_idx      (look2_idx),
    .disp_pc        (disp_pc),
    .disp_op        (disp_op),
    .disp_imm       (disp_imm),
    .disp_wen       (disp_wen),
    .disp_rd        (disp_rd),
    .disp_rs1_stall (disp_rs1_stall),
    .disp_rs1_data  (disp_rs1_data),
    .disp_rs1_link  (disp_rs1_link),
    .disp_rs2_stall (disp_rs2_stall),
    .disp_rs2_data  (disp_rs2_data),
    .disp_rs2_link  (disp_rs2_link)
  );

  ooo_rob u_rob (
    .clk            (clk),
    .rst            (rst),
    .disp_pc        (disp_pc),
    .disp_op        (disp_op),
    .disp_imm       (disp_imm),
    .disp_wen       (disp_wen),
    .disp_rd        (disp_rd),
    .disp_rs1_stall (disp_rs1_stall),
    .disp_rs1_data  (disp_rs1_data),
    .disp_rs1_link  (disp_rs1_link),
    .disp_rs2_stall (disp_rs2_stall),
    .disp_rs2_data  (disp_rs2_data),
    .disp_rs2_link  (disp_rs2_link),
    .look1_idx      (look1_idx),
    .look2_idx      (look2_idx),
    .dmem_we        (dmem_we),
    .dmem_addr      (dmem_addr),
    .dmem_data      (dmem_data),
    .squash         (squash),
    .rob_full       (rob_full),
    .rob_tail       (rob_tail),
    .look1_done     (look1_done),
    .look1_data     (look1_data),
    .look2_done     (look2_done),
    .look2_data     (look2_data),
    .head_valid     (head_valid),
    .head_idx       (head_idx),
    .head_pc        (head_pc),
    .head_wen       (head_wen),
    .head_rd        (head_rd),
    .head_data      (head_data),
    .head_is_br     (head_is_br),
    .head_taken     (head_taken),
    .head_next_pc   (head_next_pc)
  );

  ooo_commit u_commit (
    .clk          (clk),
    .rst          (rst),
    .head_valid   (head_valid),
    .head_wen     (head_wen),
    .head_rd      (head_rd),
    .head_data    (head_data),
    .head_is_br   (head_is_br),
    .head_taken   (head_taken),
    .head_next_pc (head_next_pc),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .squash       (squash),
    .squash_pc    (squash_pc),
    .wb_wen       (wb_wen),
    .wb_rd        (wb_rd),
    .rf_rs1_data  (rf_rs1_data),
    .rf_rs2_data  (rf_rs2_data)
  );

  assign commit_valid = head_valid;
  assign commit_pc    = head_pc;
  assign commit_wen   = wb_wen; // Already qualified by head_valid
  assign commit_rd    = head_rd;
  assign commit_data  = head_data;

endmodule

// File: rtl/ooo_frontend.sv
`include "ooo_consts.svh"

module ooo_frontend
  import ooo_isa_pkg::*;
  import ooo_rob_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     imem_we,
  input  pc_t                      imem_addr,
  input  logic [`OOO_INST_LEN-1:0] imem_data,
  input  logic                     squash,
  input  pc_t                      squash_pc,
  input  logic                     rob_full,
  input  rob_idx_t                 rob_tail,
  input  rob_idx_t                 head_idx,
  input  logic                     wb_wen,
  input  reg_idx_t                 wb_rd,
  input  logic                     look1_done,
  input  data_t                    look1_data,
  input  logic                     look2_done,
  input  data_t                    look2_data,
  input  data_t                    rf_rs1_data,
  input  data_t                    rf_rs2_data,
  output reg_idx_t                 rs1_idx,
  output reg_idx_t                 rs2_idx,
  output rob_idx_t                 look1_idx,
  output rob_idx_t                 look2_idx,
  output pc_t                      disp_pc,
  output opcode_e                  disp_op,
  output data_t                    disp_imm,
  output logic                     disp_wen,
  output reg_idx_t                 disp_rd,
  output logic                     disp_rs1_stall,
  output data_t                    disp_rs1_data,
  output rob_idx_t                 disp_rs1_link,
  output logic                     disp_rs2_stall,
  output data_t                    disp_rs2_data,
  output rob_idx_t                 disp_rs2_link
);

  logic [`OOO_INST_LEN-1:0] imem [`OOO_IMEM_SIZE];
  pc_t                      pc;
  inst_t                    inst;
  logic                     rs1_used;
  logic                     rs2_used;
  logic                     wen;

  logic [`OOO_RF_SIZE-1:0]  rt_valid; // Register has an in-flight producer
  rob_idx_t                 rt_link [`OOO_RF_SIZE];
  logic                     rt_set;
  logic                     rt_clear;

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_data; // Loaded by the testbench only
  end

  // Squash wins over full, prediction is always not-taken
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (squash) begin
      pc <= squash_pc;
    end else if (!rob_full) begin
      pc <= pc + 1'b1;
    end
  end

  assign inst = inst_t'(imem[pc]);

  always_comb begin
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    wen      = 1'b0;
    case (inst.op)
      OP_ADDI, OP_LD: begin
        rs1_used = 1'b1;
        wen      = 1'b1;
      end
      OP_ADD, OP_SUB: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        wen      = 1'b1;
      end
      OP_BEQ: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      default: ;
    endcase
  end

  // A newer writer of the same register keeps its entry alive
  assign rt_set   = !rob_full && wen;
  assign rt_clear = wb_wen && (rt_link[wb_rd] == head_idx) &&
                    !(rt_set && (inst.rd == wb_rd));

  always_ff @(posedge clk) begin
    if (rst || squash) begin
      rt_valid <= '0;
    end else begin
      if (rt_clear) rt_valid[wb_rd] <= 1'b0;
      if (rt_set)   rt_valid[inst.rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rt_set) rt_link[inst.rd] <= rob_tail;
  end

  assign rs1_idx   = inst.rs1;
  assign rs2_idx   = inst.rs2;
  assign look1_idx = rt_link[inst.rs1];
  assign look2_idx = rt_link[inst.rs2];

  // Renamed source reads the ROB, stalls until its producer finishes
  assign disp_rs1_stall = rs1_used && rt_valid[inst.rs1] && !look1_done;
  assign disp_rs2_stall = rs2_used && rt_valid[inst.rs2] && !look2_done;
  assign disp_rs1_data  = rt_valid[inst.rs1] ? look1_data : rf_rs1_data;
  assign disp_rs2_data  = rt_valid[inst.rs2] ? look2_data : rf_rs2_data;
  assign disp_rs1_link  = look1_idx;
  assign disp_rs2_link  = look2_idx;

  assign disp_pc  = pc;
  assign disp_op  = inst.op;
  assign disp_wen = wen;
  assign disp_rd  = inst.rd;
  assign disp_imm = (inst.op == OP_BEQ) ?
                    {{(`OOO_REG_LEN-4){inst.imm[3]}}, inst.imm} : // Signed branch offset
                    {{(`OOO_REG_LEN-4){1'b0}}, inst.imm};

endmodule

// File: rtl/ooo_isa_pkg.sv
`include "ooo_consts.svh"

package ooo_isa_pkg;

  typedef enum logic [2:0] {
    OP_NOP  = 3'd0, // No effect
    OP_ADDI = 3'd1, // rd = rs1 + imm
    OP_ADD  = 3'd2, // rd = rs1 + rs2
    OP_SUB  = 3'd3, // rd = rs1 - rs2
    OP_LD   = 3'd4, // rd = dmem[rs1 + imm]
    OP_BEQ  = 3'd5  // pc += offset when rs1 == rs2
  } opcode_e;

  typedef logic [`OOO_RF_SIZE_LOG-1:0]   reg_idx_t;
  typedef logic [`OOO_IMEM_SIZE_LOG-1:0] pc_t;
  typedef logic [`OOO_REG_LEN-1:0]       data_t;

  // Instruction word, top bit first
  typedef struct packed {
    opcode_e    op;  // Bits 15..13
    reg_idx_t   rd;  // Bits 12..10
    reg_idx_t   rs1; // Bits 9..7
    reg_idx_t   rs2; // Bits 6..4
    logic [3:0] imm; // Immediate or branch offset
  } inst_t;

endpackage

// File: rtl/ooo_rob.sv
`include "ooo_consts.svh"

module ooo_rob
  import ooo_isa_pkg::*;
  import ooo_rob_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  pc_t                           disp_pc,
  input  opcode_e                       disp_op,
  input  data_t                         disp_imm,
  input  logic                          disp_wen,
  input  reg_idx_t                      disp_rd,
  input  logic                          disp_rs1_stall,
  input  data_t                         disp_rs1_data,
  input  rob_idx_t                      disp_rs1_link,
  input  logic                          disp_rs2_stall,
  input  data_t                         disp_rs2_data,
  input  rob_idx_t                      disp_rs2_link,
  input  rob_idx_t                      look1_idx,
  input  rob_idx_t                      look2_idx,
  input  logic                          dmem_we,
  input  logic [`OOO_DMEM_SIZE_LOG-1:0] dmem_addr,
  input  data_t                         dmem_data,
  input  logic                          squash,
  output logic                          rob_full,
  output rob_idx_t                      rob_tail,
  output logic                          look1_done,
  output data_t                         look1_data,
  output logic                          look2_done,
  output data_t                         look2_data,
  output logic                          head_valid,
  output rob_idx_t                      head_idx,
  output pc_t                           head_pc,
  output logic                          head_wen,
  output reg_idx_t                      head_rd,
  output data_t                         head_data,
  output logic                          head_is_br,
  output logic                          head_taken,
  output pc_t                           head_next_pc
);

  rob_state_e state [`OOO_ROB_SIZE];
  rob_idx_t   head;
  rob_idx_t   tail;
  logic       push;

  // Entry payload
  pc_t                     e_pc       [`OOO_ROB_SIZE];
  opcode_e                 e_op       [`OOO_ROB_SIZE];
  data_t                   e_imm      [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0] e_wen;
  reg_idx_t                e_rd       [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0] e_rs1_stall;
  data_t                   e_rs1_data [`OOO_ROB_SIZE];
  rob_idx_t                e_rs1_link [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0] e_rs2_stall;
  data_t                   e_rs2_data [`OOO_ROB_SIZE];
  rob_idx_t                e_rs2_link [`OOO_ROB_SIZE];
  data_t                   e_rd_data  [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0] e_taken;
  pc_t                     e_next_pc  [`OOO_ROB_SIZE];

  data_t                         dmem [`OOO_DMEM_SIZE];
  logic [`OOO_DMEM_SIZE_LOG-1:0] alu_mem_addr [`OOO_ROB_SIZE];
  data_t                         alu_rd_data  [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0]      alu_taken;
  pc_t                           alu_next_pc  [`OOO_ROB_SIZE];

  assign rob_full = (state[tail] != ST_IDLE); // Tail slot still occupied
  assign push     = !rob_full;

  always_ff @(posedge clk) begin
    if (rst || squash) begin
      for (int i = 0; i < `OOO_ROB_SIZE; i++) state[i] <= ST_IDLE;
      head <= '0;
      tail <= '0;
    end else begin
      if (push) begin
        state[tail] <= ST_STALLED;
        tail        <= tail + 1'b1;
      end
      for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
        if (state[i] == ST_STALLED && !e_rs1_stall[i] && !e_rs2_stall[i]) begin
          state[i] <= ST_READY; // Wakeup
        end else if (state[i] == ST_READY) begin
          state[i] <= ST_FINISHED; // Execute
        end
      end
      if (head_valid) begin
        state[head] <= ST_IDLE; // Pop
        head        <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      e_pc[tail]        <= disp_pc;
      e_op[tail]        <= disp_op;
      e_imm[tail]       <= disp_imm;
      e_wen[tail]       <= disp_wen;
      e_rd[tail]        <= disp_rd;
      e_rs1_stall[tail] <= disp_rs1_stall;
      e_rs1_data[tail]  <= disp_rs1_data;
      e_rs1_link[tail]  <= disp_rs1_link;
      e_rs2_stall[tail] <= disp_rs2_stall;
      e_rs2_data[tail]  <= disp_rs2_data;
      e_rs2_link[tail]  <= disp_rs2_link;
    end
    for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
      if (state[i] == ST_READY) begin
        e_rd_data[i] <= alu_rd_data[i];
        e_taken[i]   <= alu_taken[i];
        e_next_pc[i] <= alu_next_pc[i];
      end
    end
    // Finished entries feed every stalled source linked to them
    for (int j = 0; j < `OOO_ROB_SIZE; j++) begin
      for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
        if (state[i] == ST_FINISHED && state[j] == ST_STALLED) begin
          if (e_rs1_stall[j] && e_rs1_link[j] == rob_idx_t'(i)) begin
            e_rs1_stall[j] <= 1'b0;
            e_rs1_data[j]  <= e_rd_data[i];
          end
          if (e_rs2_stall[j] && e_rs2_link[j] == rob_idx_t'(i)) begin
            e_rs2_stall[j] <= 1'b0;
            e_rs2_data[j]  <= e_rd_data[i];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr] <= dmem_data;
  end

  for (genvar p = 0; p < `OOO_ROB_SIZE; p++) begin : g_alu
    ooo_alu u_alu (
      .pc       (e_pc[p]),
      .op       (e_op[p]),
      .imm      (e_imm[p]),
      .rs1_data (e_rs1_data[p]),
      .rs2_data (e_rs2_data[p]),
      .mem_data (dmem[alu_mem_addr[p]]),
      .mem_addr (alu_mem_addr[p]),
      .rd_data  (alu_rd_data[p]),
      .taken    (alu_taken[p]),
      .next_pc  (alu_next_pc[p])
    );
  end

  assign rob_tail   = tail;
  assign look1_done = (state[look1_idx] == ST_FINISHED);
  assign look1_data = e_rd_data[look1_idx];
  assign look2_done = (state[look2_idx] == ST_FINISHED);
  assign look2_data = e_rd_data[look2_idx];

  assign head_valid   = (state[head] == ST_FINISHED);
  assign head_idx     = head;
  assign head_pc      = e_pc[head];
  assign head_wen     = e_wen[head];
  assign head_rd      = e_rd[head];
  assign head_data    = e_rd_data[head];
  assign head_is_br   = (e_op[head] == OP_BEQ);
  assign head_taken   = e_taken[head];
  assign head_next_pc = e_next_pc[head];

endmodule

// File: rtl/ooo_rob_pkg.sv
`include "ooo_consts.svh"

package ooo_rob_pkg;

  // Life cycle of one ROB entry
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0, // Free slot
    ST_STALLED  = 2'd1, // Waiting for source operands
    ST_READY    = 2'd2, // Operands present, executes this cycle
    ST_FINISHED = 2'd3  // Result valid, may commit
  } rob_state_e;

  typedef logic [`OOO_ROB_SIZE_LOG-1:0] rob_idx_t;

endpackage

// File: testbench/ooo_checker.sv
module ooo_checker
  import ooo_isa_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic commit_valid,
  input pc_t  commit_pc,
  input logic commit_wen,
  input logic squash,
  input pc_t  squash_pc,
  input logic rob_full
);
  timeunit 1ns;
  timeprecision 100ps;

  logic redirect_pending; // Squash seen and target not yet committed
  pc_t  redirect_target;

  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_pending <= 1'b0;
      redirect_target  <= '0;
    end else if (squash) begin
      redirect_pending <= 1'b1;
      redirect_target  <= squash_pc;
    end else if (commit_valid) begin
      redirect_pending <= 1'b0;
    end
  end

  // A taken branch at the head never writes a register
  wen_needs_valid: assert property (@(posedge clk) disable iff (rst)
    commit_wen |-> (commit_valid && !squash))
    else $error("commit_wen high without commit_valid or during a squash");

  commit_at_target: assert property (@(posedge clk) disable iff (rst)
    (redirect_pending && commit_valid) |-> (commit_pc == redirect_target))
    else $error("first commit after squash is not at the branch target");

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (!rob_full && !commit_valid))
    else $error("rob_full or commit_valid high right after reset");

endmodule

bind ooo_core ooo_checker u_checker (
  .clk          (clk),
  .rst          (rst),
  .commit_valid (commit_valid),
  .commit_pc    (commit_pc),
  .commit_wen   (commit_wen),
  .squash       (squash),
  .squash_pc    (squash_pc),
  .rob_full     (rob_full)
);

// File: testbench/ooo_tb.sv
`include "ooo_consts.svh"

module ooo_tb
  import ooo_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS  = 23;
  localparam int MAX_CYCLE = NUM_ROWS * 20 + 50;

  typedef struct packed {
    pc_t      pc;
    logic     wen;
    reg_idx_t rd;
    data_t    data;
  } row_t;

  logic                          clk;
  logic                          rst;
  logic                          load_busy;
  logic                          imem_we;
  pc_t                           imem_addr;
  logic [`OOO_INST_LEN-1:0]      imem_data;
  logic                          dmem_we;
  logic [`OOO_DMEM_SIZE_LOG-1:0] dmem_addr;
  data_t                         dmem_data;
  logic                          commit_valid;
  pc_t                           commit_pc;
  logic                          commit_wen;
  reg_idx_t                      commit_rd;
  data_t                         commit_data;

  logic [`OOO_INST_LEN-1:0] prog_tab [`OOO_IMEM_SIZE];
  data_t                    data_tab [`OOO_DMEM_SIZE];
  row_t                     exp_tab  [NUM_ROWS];
  int                       cycles;
  logic                     seen_full; // ROB back-pressure observed

  tb_clock_gen u_clk (
    .load_busy (load_busy),
    .clk       (clk),
    .rst       (rst)
  );

  ooo_core uut (
    .clk          (clk),
    .rst          (rst),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dmem_we      (dmem_we),
    .dmem_addr    (dmem_addr),
    .dmem_data    (dmem_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  function automatic logic [15:0] encode_inst(opcode_e op, reg_idx_t rd, reg_idx_t rs1,
                                              reg_idx_t rs2, logic [3:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  task automatic fill_tables();
    for (int a = 0; a < `OOO_IMEM_SIZE; a++) prog_tab[a] = encode_inst(OP_NOP, 0, 0, 0, 0);
    for (int a = 0; a < `OOO_DMEM_SIZE; a++) begin
      data_tab[a] = {a[3:0], ~a[3:0], a[3:0] ^ 4'h5, 4'h3}; // Unique per address
    end
    // Independent arithmetic
    prog_tab[0]  = encode_inst(OP_ADDI, 1, 0, 0, 4'd5);
    prog_tab[1]  = encode_inst(OP_ADDI, 2, 0, 0, 4'd3);
    prog_tab[2]  = encode_inst(OP_ADD,  3, 1, 2, 4'd0);
    prog_tab[3]  = encode_inst(OP_SUB,  4, 1, 2, 4'd0);
    // Dependent chain that backs up the ROB
    prog_tab[4]  = encode_inst(OP_ADDI, 5, 0, 0, 4'd1);
    prog_tab[5]  = encode_inst(OP_ADDI, 5, 5, 0, 4'd2);
    prog_tab[6]  = encode_inst(OP_ADD,  5, 5, 5, 4'd0);
    prog_tab[7]  = encode_inst(OP_SUB,  6, 5, 4, 4'd0);
    prog_tab[8]  = encode_inst(OP_ADDI, 6, 6, 0, 4'd7);
    prog_tab[9]  = encode_inst(OP_ADD,  6, 6, 5, 4'd0);
    prog_tab[10] = encode_inst(OP_ADDI, 6, 6, 0, 4'd15);
    prog_tab[11] = encode_inst(OP_SUB,  6, 6, 1, 4'd0);
    // 12 and 13 stay NOP
    prog_tab[14] = encode_inst(OP_LD,   7, 4, 0, 4'd9);  // Address 11
    prog_tab[15] = encode_inst(OP_LD,   1, 3, 0, 4'd10); // 18 wraps to 2
    prog_tab[16] = encode_inst(OP_BEQ,  0, 2, 4, 4'd3);  // Not taken
    prog_tab[17] = encode_inst(OP_BEQ,  0, 3, 3, 4'd4);  // Taken to 21
    prog_tab[18] = encode_inst(OP_ADDI, 2, 0, 0, 4'd15);
    prog_tab[19] = encode_inst(OP_ADDI, 3, 0, 0, 4'd15);
    prog_tab[21] = encode_inst(OP_ADDI, 2, 2, 0, 4'd1);
    prog_tab[22] = encode_inst(OP_SUB,  3, 2, 1, 4'd0);
    prog_tab[23] = encode_inst(OP_BEQ,  0, 0, 0, 4'd2);  // Taken to 25
    prog_tab[24] = encode_inst(OP_ADDI, 7, 0, 0, 4'd1);
    prog_tab[25] = encode_inst(OP_ADD,  4, 3, 2, 4'd0);

    exp_tab[0]  = '{5'd0,  1'b1, 3'd1, 16'h0005};
    exp_tab[1]  = '{5'd1,  1'b1, 3'd2, 16'h0003};
    exp_tab[2]  = '{5'd2,  1'b1, 3'd3, 16'h0008};
    exp_tab[3]  = '{5'd3,  1'b1, 3'd4, 16'h0002};
    exp_tab[4]  = '{5'd4,  1'b1, 3'd5, 16'h0001};
    exp_tab[5]  = '{5'd5,  1'b1, 3'd5, 16'h0003};
    exp_tab[6]  = '{5'd6,  1'b1, 3'd5, 16'h0006};
    exp_tab[7]  = '{5'd7,  1'b1, 3'd6, 16'h0004};
    exp_tab[8]  = '{5'd8,  1'b1, 3'd6, 16'h000b};
    exp_tab[9]  = '{5'd9,  1'b1, 3'd6, 16'h0011};
    exp_tab[10] = '{5'd10, 1'b1, 3'd6, 16'h0020};
    exp_tab[11] = '{5'd11, 1'b1, 3'd6, 16'h001b};
    exp_tab[12] = '{5'd12, 1'b0, 3'd0, 16'h0000};
    exp_tab[13] = '{5'd13, 1'b0, 3'd0, 16'h0000};
    exp_tab[14] = '{5'd14, 1'b1, 3'd7, 16'hb4e3};
    exp_tab[15] = '{5'd15, 1'b1, 3'd1, 16'h2d73};
    exp_tab[16] = '{5'd16, 1'b0, 3'd0, 16'h0000};
    exp_tab[17] = '{5'd17, 1'b0, 3'd0, 16'h0000};
    exp_tab[18] = '{5'd21, 1'b1, 3'd2, 16'h0004};
    exp_tab[19] = '{5'd22, 1'b1, 3'd3, 16'hd291}; // 4 - 0x2d73
    exp_tab[20] = '{5'd23, 1'b0, 3'd0, 16'h0000};
    exp_tab[21] = '{5'd25, 1'b1, 3'd4, 16'hd295};
    exp_tab[22] = '{5'd26, 1'b0, 3'd0, 16'h0000};
  endtask

  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] want);
    assert (got === want) else begin
      $display("ERR %s got %h expected %h", name, got, want);
      $display("** FAIL **");
      $fatal(1, "Commit mismatch");
    end
  endtask

  task automatic wait_commit();
    do @(negedge clk); while (!commit_valid);
  endtask

  // Run limit counted from the end of reset
  always @(posedge clk) begin
    if (!rst) cycles <= cycles + 1;
    if (cycles > MAX_CYCLE) begin
      $display("Timeout: the core stopped committing before all expected rows");
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

  always @(posedge clk) begin
    if (!rst && uut.rob_full) seen_full <= 1'b1;
  end

  initial begin
    row_t row;
    cycles    = 0;
    seen_full = 1'b0;
    load_busy = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    dmem_we   = 1'b0;
    dmem_addr = '0;
    dmem_data = '0;
    fill_tables();

    // Both memories load side by side while reset is held
    for (int a = 0; a < `OOO_IMEM_SIZE; a++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= pc_t'(a);
      imem_data <= prog_tab[a];
      dmem_we   <= (a < `OOO_DMEM_SIZE);
      dmem_addr <= a[`OOO_DMEM_SIZE_LOG-1:0];
      dmem_data <= data_tab[a[`OOO_DMEM_SIZE_LOG-1:0]];
    end
    @(posedge clk);
    imem_we   <= 1'b0;
    dmem_we   <= 1'b0;
    load_busy <= 1'b0;

    for (int k = 0; k < NUM_ROWS; k++) begin
      row = exp_tab[k];
      wait_commit();
      compare_field("commit_pc", 16'(commit_pc), 16'(row.pc));
      compare_field("commit_wen", 16'(commit_wen), 16'(row.wen));
      if (row.wen) begin // Only writes carry a meaningful rd and data
        compare_field("commit_rd", 16'(commit_rd), 16'(row.rd));
        compare_field("commit_data", commit_data, row.data);
      end
    end

    assert (seen_full) else begin
      $display("The ROB never filled during the program");
      $display("** FAIL **");
      $fatal(1, "No back-pressure");
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
  input  logic load_busy,
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #4 clk = ~clk; // 8 ns period

  // Reset stays up while memories load, then two more cycles
  initial begin
    rst = 1'b1;
    @(posedge clk);
    while (load_busy) @(posedge clk);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
